/* compile.f */
design/eeprom_cfg_pkg.sv
design/eeprom_op_pkg.sv
design/sync_fifo.sv
design/eeprom_op_sequencer.sv
design/read_stream_framer.sv
design/eeprom_ctrl.sv
verification/tb_eeprom_ctrl.sv

/* design/eeprom_cfg_pkg.sv */
// EEPROM controller configuration

package eeprom_cfg_pkg;

    // user side device select and bus side device address
    localparam int DEV_W     = 3;
    localparam int BUS_DEV_W = 7;

    // upper device bits sit above the user select
    localparam logic [BUS_DEV_W-DEV_W-1:0] DEV_PREFIX = '0;

    localparam int ADDR_W = 16;
    localparam int LEN_W  = 8;
    localparam int DATA_W = 8;

    // one entry more than the longest transfer
    localparam int FIFO_DEPTH = 256;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;

endpackage

/* design/eeprom_ctrl.sv */
// EEPROM access controller
`timescale 1ns/100ps

module eeprom_ctrl (
    input  logic                                i_clk,
    input  logic                                i_rst,

    // IIC master side
    output logic [eeprom_cfg_pkg::BUS_DEV_W-1:0] o_operation_device,
    output eeprom_cfg_pkg::addr_t                o_operation_addr,
    output eeprom_cfg_pkg::len_t                 o_operation_len,
    output eeprom_op_pkg::op_type_e              o_operation_type,
    output logic                                o_operation_valid,
    input  logic                                i_operation_ready,
    output eeprom_cfg_pkg::data_t                o_write_data,
    input  logic                                i_write_req,
    input  eeprom_cfg_pkg::data_t                i_read_data,
    input  logic                                i_read_valid,

    // user side
    input  logic [eeprom_cfg_pkg::DEV_W-1:0]     i_user_device_addr,
    input  eeprom_cfg_pkg::addr_t                i_user_operate_addr,
    input  eeprom_cfg_pkg::len_t                 i_user_operate_len,
    input  eeprom_op_pkg::op_type_e              i_user_operate_type,
    input  logic                                i_user_operate_valid,
    output logic                                o_user_operate_ready,
    input  eeprom_cfg_pkg::data_t                i_user_write_data,
    input  logic                                i_user_write_valid,
    output eeprom_cfg_pkg::data_t                o_user_read_data,
    output logic                                o_user_read_sop,
    output logic                                o_user_read_eop,
    output logic                                o_user_read_valid
);

    eeprom_cfg_pkg::data_t wr_data_q;
    logic                  wr_valid_q;
    eeprom_cfg_pkg::data_t rd_data_q;
    logic                  rd_valid_q;
    eeprom_cfg_pkg::data_t rd_fifo_dout;
    logic                  rd_fifo_pop;
    logic                  drain_start;
    eeprom_cfg_pkg::len_t  drain_len;
    logic                  drain_done;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            wr_valid_q <= 1'b0;
            rd_valid_q <= 1'b0;
        end
        else
        begin
            wr_valid_q <= i_user_write_valid;
            rd_valid_q <= i_read_valid;
        end
    end

    always_ff @(posedge i_clk)
    begin
        wr_data_q <= i_user_write_data;
        rd_data_q <= i_read_data;
    end

    // bytes waiting for the bus to pull them
    sync_fifo #(
        .T     (eeprom_cfg_pkg::data_t),
        .DEPTH (eeprom_cfg_pkg::FIFO_DEPTH)
    ) u_write_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (wr_valid_q),
        .i_din   (wr_data_q),
        .i_pop   (i_write_req),
        .o_dout  (o_write_data),
        .o_empty (),
        .o_full  ()
    );

    sync_fifo #(
        .T     (eeprom_cfg_pkg::data_t),
        .DEPTH (eeprom_cfg_pkg::FIFO_DEPTH)
    ) u_read_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (rd_valid_q),
        .i_din   (rd_data_q),
        .i_pop   (rd_fifo_pop),
        .o_dout  (rd_fifo_dout),
        .o_empty (),
        .o_full  ()
    );

    eeprom_op_sequencer u_sequencer (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req_dev     (i_user_device_addr),
        .i_req_addr    (i_user_operate_addr),
        .i_req_len     (i_user_operate_len),
        .i_req_type    (i_user_operate_type),
        .i_req_valid   (i_user_operate_valid),
        .o_req_ready   (o_user_operate_ready),
        .o_op_dev      (o_operation_device),
        .o_op_addr     (o_operation_addr),
        .o_op_len      (o_operation_len),
        .o_op_type     (o_operation_type),
        .o_op_valid    (o_operation_valid),
        .i_op_ready    (i_operation_ready),
        .o_drain_start (drain_start),
        .o_drain_len   (drain_len),
        .i_drain_done  (drain_done)
    );

    read_stream_framer u_framer (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (drain_start),
        .i_len       (drain_len),
        .i_fifo_data (rd_fifo_dout),
        .o_fifo_pop  (rd_fifo_pop),
        .o_data      (o_user_read_data),
        .o_sop       (o_user_read_sop),
        .o_eop       (o_user_read_eop),
        .o_valid     (o_user_read_valid),
        .o_done      (drain_done)
    );

endmodule

/* design/eeprom_op_pkg.sv */
// EEPROM operation codes and sequencer states

package eeprom_op_pkg;

    // codes seen by the IIC master
    typedef enum logic [1:0] {
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } op_type_e;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        // operation valid, waiting for the bus to take it
        ST_ISSUE      = 3'd1,
        ST_WRITE_WAIT = 3'd2,
        ST_READ_WAIT  = 3'd3,
        // step the address for the next single byte read
        ST_READ_NEXT  = 3'd4,
        ST_SETTLE     = 3'd5,
        // framer is emptying the read FIFO
        ST_DRAIN      = 3'd6
    } seq_state_e;

endpackage

/* design/eeprom_op_sequencer.sv */
// EEPROM operation sequencer
`timescale 1ns/100ps

module eeprom_op_sequencer (
    input  logic                                i_clk,
    input  logic                                i_rst,

    input  logic [eeprom_cfg_pkg::DEV_W-1:0]     i_req_dev,
    input  eeprom_cfg_pkg::addr_t                i_req_addr,
    input  eeprom_cfg_pkg::len_t                 i_req_len,
    input  eeprom_op_pkg::op_type_e              i_req_type,
    input  logic                                i_req_valid,
    output logic                                o_req_ready,

    output logic [eeprom_cfg_pkg::BUS_DEV_W-1:0] o_op_dev,
    output eeprom_cfg_pkg::addr_t                o_op_addr,
    output eeprom_cfg_pkg::len_t                 o_op_len,
    output eeprom_op_pkg::op_type_e              o_op_type,
    output logic                                o_op_valid,
    input  logic                                i_op_ready,

    output logic                                o_drain_start,
    output eeprom_cfg_pkg::len_t                 o_drain_len,
    input  logic                                i_drain_done
);

    eeprom_op_pkg::seq_state_e state;
    eeprom_op_pkg::seq_state_e state_nxt;

    eeprom_cfg_pkg::len_t len_q;
    eeprom_cfg_pkg::len_t done_cnt;
    logic                 ready_d;
    logic                 settle_cnt;
    logic                 accept;
    logic                 take;
    logic                 ready_rise;

    assign accept     = i_req_valid && o_req_ready;
    assign take       = o_op_valid && i_op_ready;
    // bus ready coming back marks the end of an operation
    assign ready_rise = i_op_ready && !ready_d;

    assign o_drain_len = len_q;

    always_comb
    begin
        state_nxt = state;
        case (state)
            eeprom_op_pkg::ST_IDLE:
                if (accept)
                    state_nxt = eeprom_op_pkg::ST_ISSUE;
            eeprom_op_pkg::ST_ISSUE:
                if (take)
                    state_nxt = (o_op_type == eeprom_op_pkg::OP_WRITE) ?
                                eeprom_op_pkg::ST_WRITE_WAIT : eeprom_op_pkg::ST_READ_WAIT;
            eeprom_op_pkg::ST_WRITE_WAIT:
                if (ready_rise)
                    state_nxt = eeprom_op_pkg::ST_IDLE;
            eeprom_op_pkg::ST_READ_WAIT:
                if (ready_rise)
                    state_nxt = (done_cnt == len_q - 1'b1) ?
                                eeprom_op_pkg::ST_SETTLE : eeprom_op_pkg::ST_READ_NEXT;
            eeprom_op_pkg::ST_READ_NEXT:
                state_nxt = eeprom_op_pkg::ST_ISSUE;
            eeprom_op_pkg::ST_SETTLE:
                if (settle_cnt)
                    state_nxt = eeprom_op_pkg::ST_DRAIN;
            eeprom_op_pkg::ST_DRAIN:
                if (i_drain_done)
                    state_nxt = eeprom_op_pkg::ST_IDLE;
            default:
                state_nxt = eeprom_op_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            state         <= eeprom_op_pkg::ST_IDLE;
            ready_d       <= 1'b1;
            o_req_ready   <= 1'b1;
            o_op_valid    <= 1'b0;
            done_cnt      <= '0;
            settle_cnt    <= 1'b0;
            o_drain_start <= 1'b0;
        end
        else
        begin
            state      <= state_nxt;
            ready_d    <= i_op_ready;
            settle_cnt <= (state == eeprom_op_pkg::ST_SETTLE) ? !settle_cnt : 1'b0;
            o_drain_start <= (state == eeprom_op_pkg::ST_SETTLE) && settle_cnt;

            if (accept)
                o_req_ready <= 1'b0;
            else if (state == eeprom_op_pkg::ST_IDLE)
                o_req_ready <= 1'b1;

            if (accept || state == eeprom_op_pkg::ST_READ_NEXT)
                o_op_valid <= 1'b1;
            else if (take)
                o_op_valid <= 1'b0;

            // completed single byte reads
            if (state == eeprom_op_pkg::ST_IDLE)
                done_cnt <= '0;
            else if (state == eeprom_op_pkg::ST_READ_WAIT && ready_rise)
                done_cnt <= done_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            len_q     <= i_req_len;
            o_op_dev  <= {eeprom_cfg_pkg::DEV_PREFIX, i_req_dev};
            o_op_addr <= i_req_addr;
            o_op_type <= i_req_type;
            // reads go out one byte at a time
            o_op_len  <= (i_req_type == eeprom_op_pkg::OP_READ) ?
                         eeprom_cfg_pkg::len_t'(1) : i_req_len;
        end
        else if (state == eeprom_op_pkg::ST_READ_NEXT)
            o_op_addr <= o_op_addr + 1'b1;
    end

    a_op_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_op_valid && !i_op_ready |=> o_op_valid && $stable(o_op_dev) &&
        $stable(o_op_addr) && $stable(o_op_len) && $stable(o_op_type));

    a_len_nonzero: assert property (@(posedge i_clk) disable iff (i_rst)
        accept |-> i_req_len != '0);

    a_type_legal: assert property (@(posedge i_clk) disable iff (i_rst)
        accept |-> i_req_type inside {eeprom_op_pkg::OP_WRITE, eeprom_op_pkg::OP_READ});

endmodule

/* design/read_stream_framer.sv */
// Read packet framer
`timescale 1ns/100ps

module read_stream_framer (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_start,
    input  eeprom_cfg_pkg::len_t i_len,
    input  eeprom_cfg_pkg::data_t i_fifo_data,
    output logic                 o_fifo_pop,
    output eeprom_cfg_pkg::data_t o_data,
    output logic                 o_sop,
    output logic                 o_eop,
    output logic                 o_valid,
    output logic                 o_done
);

    eeprom_cfg_pkg::len_t pop_left;
    logic                 last_pop;
    logic                 pop_d;
    logic                 first_d;
    logic                 last_d;

    // first pop goes out with the start pulse
    assign o_fifo_pop = i_start || (pop_left != '0);
    assign last_pop   = i_start ? (i_len == eeprom_cfg_pkg::len_t'(1)) :
                                  (pop_left == eeprom_cfg_pkg::len_t'(1));
    assign o_done     = o_eop;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            pop_left <= '0;
            pop_d    <= 1'b0;
            first_d  <= 1'b0;
            last_d   <= 1'b0;
            o_valid  <= 1'b0;
            o_sop    <= 1'b0;
            o_eop    <= 1'b0;
        end
        else
        begin
            if (i_start)
                pop_left <= i_len - 1'b1;
            else if (pop_left != '0)
                pop_left <= pop_left - 1'b1;
            // marks follow the FIFO read latency
            pop_d   <= o_fifo_pop;
            first_d <= i_start;
            last_d  <= o_fifo_pop && last_pop;
            o_valid <= pop_d;
            o_sop   <= first_d;
            o_eop   <= last_d;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (pop_d)
            o_data <= i_fifo_data;
    end

    // sop opens a packet and eop closes it
    a_sop_first: assert property (@(posedge i_clk) disable iff (i_rst)
        o_sop |-> o_valid && !$past(o_valid));
    a_eop_last: assert property (@(posedge i_clk) disable iff (i_rst)
        o_eop |=> !o_valid);

endmodule

/* design/sync_fifo.sv */
// Single clock FIFO
`timescale 1ns/100ps

module sync_fifo #(
    parameter type T     = eeprom_cfg_pkg::data_t,
    parameter int  DEPTH = eeprom_cfg_pkg::FIFO_DEPTH
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_push,
    input  T     i_din,
    input  logic i_pop,
    output T     o_dout,
    output logic o_empty,
    output logic o_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T               mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic           wr_en;
    logic           rd_en;

    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign wr_en   = i_push && !o_full;
    assign rd_en   = i_pop && !o_empty;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

    // storage and read port
    always_ff @(posedge i_clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= i_din;
        if (rd_en)
            o_dout <= mem[rd_ptr];
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst) i_push |-> !o_full);
    a_no_underflow: assert property (@(posedge i_clk) disable iff (i_rst) i_pop |-> !o_empty);

endmodule

/* run.sh */
#!/bin/sh
# Verilator build and run of the EEPROM controller testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_eeprom_ctrl -f compile.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log
if grep -q "Simulation passed" sim.log; then
    exit 0
fi
exit 1

/* verification/tb_eeprom_ctrl.sv */
// EEPROM controller testbench
`timescale 1ns/100ps

module tb_eeprom_ctrl;

    localparam int          CLK_PERIOD     = 8;
    localparam int          NUM_TXNS       = 40;
    localparam logic [31:0] SEED           = 32'hc5a0_0eb9;
    localparam int          BUS_IDLE_LIMIT = 4000;
    localparam int          BYTE_LIMIT     = 40;

    typedef logic [eeprom_cfg_pkg::DEV_W-1:0]     dev_t;
    typedef logic [eeprom_cfg_pkg::BUS_DEV_W-1:0] bus_dev_t;

    typedef struct packed {
        bus_dev_t                dev;
        eeprom_cfg_pkg::addr_t   addr;
        eeprom_cfg_pkg::len_t    len;
        eeprom_op_pkg::op_type_e typ;
    } op_t;

    logic                    i_clk;
    logic                    i_rst;
    bus_dev_t                o_operation_device;
    eeprom_cfg_pkg::addr_t   o_operation_addr;
    eeprom_cfg_pkg::len_t    o_operation_len;
    eeprom_op_pkg::op_type_e o_operation_type;
    logic                    o_operation_valid;
    logic                    i_operation_ready;
    eeprom_cfg_pkg::data_t   o_write_data;
    logic                    i_write_req;
    eeprom_cfg_pkg::data_t   i_read_data;
    logic                    i_read_valid;
    dev_t                    i_user_device_addr;
    eeprom_cfg_pkg::addr_t   i_user_operate_addr;
    eeprom_cfg_pkg::len_t    i_user_operate_len;
    eeprom_op_pkg::op_type_e i_user_operate_type;
    logic                    i_user_operate_valid;
    logic                    o_user_operate_ready;
    eeprom_cfg_pkg::data_t   i_user_write_data;
    logic                    i_user_write_valid;
    eeprom_cfg_pkg::data_t   o_user_read_data;
    logic                    o_user_read_sop;
    logic                    o_user_read_eop;
    logic                    o_user_read_valid;

    // EEPROM contents as the bus sees them
    eeprom_cfg_pkg::data_t mem [65536];
    eeprom_cfg_pkg::data_t wr_bytes [$];
    op_t                   exp_ops [$];
    int                    ops_issued;
    int                    ops_done;

    eeprom_ctrl UUT (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic abort_run(input string what);
        $display("Error: %s at %0t ns", what, $time);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("** Error: %s expected 0x%h, got 0x%h at %0t ns",
                     name, expected, actual, $time);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic compare_operation(input op_t exp);
        check_value("o_operation_valid", 1, 32'(o_operation_valid));
        check_value("o_operation_device", 32'(exp.dev), 32'(o_operation_device));
        check_value("o_operation_addr", 32'(exp.addr), 32'(o_operation_addr));
        check_value("o_operation_len", 32'(exp.len), 32'(o_operation_len));
        check_value("o_operation_type", 32'(exp.typ), 32'(o_operation_type));
    endtask

    task automatic expect_operation(input dev_t dev, input eeprom_cfg_pkg::addr_t addr,
                                    input eeprom_cfg_pkg::len_t len,
                                    input eeprom_op_pkg::op_type_e typ);
        op_t op;
        op.dev  = {eeprom_cfg_pkg::DEV_PREFIX, dev};
        op.addr = addr;
        op.len  = len;
        op.typ  = typ;
        exp_ops.push_back(op);
        ops_issued++;
    endtask

    task automatic send_request(input dev_t dev, input eeprom_cfg_pkg::addr_t addr,
                                input eeprom_cfg_pkg::len_t len,
                                input eeprom_op_pkg::op_type_e typ);
        int cnt;
        i_user_device_addr   = dev;
        i_user_operate_addr  = addr;
        i_user_operate_len   = len;
        i_user_operate_type  = typ;
        i_user_operate_valid = 1'b1;
        cnt = 0;
        while (!o_user_operate_ready)
        begin
            @(negedge i_clk);
            cnt++;
            if (cnt > 100)
                abort_run("user request was never accepted");
        end
        @(negedge i_clk);
        i_user_operate_valid = 1'b0;
        check_value("o_user_operate_ready", 0, 32'(o_user_operate_ready));
        check_value("o_operation_valid", 1, 32'(o_operation_valid));
    endtask

    task automatic wait_user_ready(input int limit);
        int cnt;
        cnt = 0;
        while (!o_user_operate_ready)
        begin
            @(negedge i_clk);
            cnt++;
            if (cnt > limit)
                abort_run("user ready did not come back");
        end
        // ready must not return before the bus finished every operation
        check_value("completed operations", ops_issued, ops_done);
    endtask

    task automatic run_write(input dev_t dev, input eeprom_cfg_pkg::addr_t addr,
                             input eeprom_cfg_pkg::len_t len);
        eeprom_cfg_pkg::data_t b;
        for (int i = 0; i < int'(len); i++)
        begin
            b = eeprom_cfg_pkg::data_t'($urandom);
            wr_bytes.push_back(b);
            i_user_write_data  = b;
            i_user_write_valid = 1'b1;
            @(negedge i_clk);
        end
        i_user_write_valid = 1'b0;
        expect_operation(dev, addr, len, eeprom_op_pkg::OP_WRITE);
        send_request(dev, addr, len, eeprom_op_pkg::OP_WRITE);
        wait_user_ready(int'(len) * BYTE_LIMIT + 100);
    endtask

    task automatic run_read(input dev_t dev, input eeprom_cfg_pkg::addr_t addr,
                            input eeprom_cfg_pkg::len_t len);
        int cnt;
        for (int k = 0; k < int'(len); k++)
            expect_operation(dev, eeprom_cfg_pkg::addr_t'(addr + k),
                             eeprom_cfg_pkg::len_t'(1), eeprom_op_pkg::OP_READ);
        send_request(dev, addr, len, eeprom_op_pkg::OP_READ);
        cnt = 0;
        while (!o_user_read_valid)
        begin
            check_value("o_user_operate_ready", 0, 32'(o_user_operate_ready));
            @(negedge i_clk);
            cnt++;
            if (cnt > int'(len) * BYTE_LIMIT + 100)
                abort_run("read packet never started");
        end
        check_value("completed operations", ops_issued, ops_done);
        for (int i = 0; i < int'(len); i++)
        begin
            check_value("o_user_read_valid", 1, 32'(o_user_read_valid));
            check_value("o_user_read_data", 32'(mem[eeprom_cfg_pkg::addr_t'(addr + i)]),
                        32'(o_user_read_data));
            check_value("o_user_read_sop", 32'(i == 0), 32'(o_user_read_sop));
            check_value("o_user_read_eop", 32'(i == int'(len) - 1), 32'(o_user_read_eop));
            check_value("o_user_operate_ready", 0, 32'(o_user_operate_ready));
            @(negedge i_clk);
        end
        check_value("o_user_read_valid", 0, 32'(o_user_read_valid));
        wait_user_ready(20);
    endtask

    task automatic pull_write_bytes(input op_t op);
        eeprom_cfg_pkg::data_t b;
        for (int i = 0; i < int'(op.len); i++)
        begin
            repeat ($urandom % 3) @(negedge i_clk);
            i_write_req = 1'b1;
            @(negedge i_clk);
            i_write_req = 1'b0;
            b = wr_bytes.pop_front();
            check_value("o_write_data", 32'(b), 32'(o_write_data));
            mem[eeprom_cfg_pkg::addr_t'(op.addr + i)] = b;
        end
    endtask

    task automatic return_read_byte(input op_t op);
        repeat ($urandom % 4) @(negedge i_clk);
        i_read_data  = mem[op.addr];
        i_read_valid = 1'b1;
        @(negedge i_clk);
        i_read_valid = 1'b0;
    endtask

    // IIC master model
    initial
    begin : bus_model
        op_t exp;
        int  cnt;
        i_operation_ready = 1'b1;
        i_write_req       = 1'b0;
        i_read_data       = '0;
        i_read_valid      = 1'b0;
        @(negedge i_clk);
        forever
        begin
            cnt = 0;
            while (!o_operation_valid)
            begin
                @(negedge i_clk);
                cnt++;
                if (cnt > BUS_IDLE_LIMIT)
                    abort_run("no operation reached the bus");
            end
            if (exp_ops.size() == 0)
                abort_run("bus saw an operation that was not requested");
            exp = exp_ops.pop_front();
            compare_operation(exp);
            // a busy bus makes the operation wait
            if (!i_operation_ready)
            begin
                repeat (1 + $urandom % 4)
                begin
                    @(negedge i_clk);
                    compare_operation(exp);
                end
                i_operation_ready = 1'b1;
            end
            @(negedge i_clk);
            check_value("o_operation_valid", 0, 32'(o_operation_valid));
            i_operation_ready = 1'b0;
            if (exp.typ == eeprom_op_pkg::OP_WRITE)
                pull_write_bytes(exp);
            else
                return_read_byte(exp);
            repeat (1 + $urandom % 4) @(negedge i_clk);
            ops_done++;
            i_operation_ready = 1'b1;
            @(negedge i_clk);
            if ($urandom % 2)
                i_operation_ready = 1'b0;
        end
    end

    initial
    begin : stimulus
        dev_t                  dev;
        eeprom_cfg_pkg::addr_t addr;
        eeprom_cfg_pkg::len_t  len;
        void'($urandom(SEED));
        for (int a = 0; a < 65536; a++)
            mem[16'(a)] = eeprom_cfg_pkg::data_t'((a >> 8) ^ (a * 13) ^ 'h5a);
        ops_issued           = 0;
        ops_done             = 0;
        i_rst                = 1'b1;
        i_user_device_addr   = '0;
        i_user_operate_addr  = '0;
        i_user_operate_len   = '0;
        i_user_operate_type  = eeprom_op_pkg::OP_WRITE;
        i_user_operate_valid = 1'b0;
        i_user_write_data    = '0;
        i_user_write_valid   = 1'b0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        check_value("o_user_operate_ready", 1, 32'(o_user_operate_ready));
        check_value("o_operation_valid", 0, 32'(o_operation_valid));
        check_value("o_user_read_valid", 0, 32'(o_user_read_valid));
        check_value("o_user_read_sop", 0, 32'(o_user_read_sop));
        check_value("o_user_read_eop", 0, 32'(o_user_read_eop));
        // window around the top of memory so reads overlap writes and wrap
        for (int t = 0; t < NUM_TXNS; t++)
        begin
            dev  = dev_t'($urandom);
            addr = eeprom_cfg_pkg::addr_t'(16'hff80 + ($urandom % 256));
            len  = eeprom_cfg_pkg::len_t'(1 + ($urandom % 255));
            if ($urandom % 2)
                run_read(dev, addr, len);
            else
                run_write(dev, addr, len);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule
